/* logic/exec_cfg.svh */
/*
 * Width definitions for the simple integer execution lane.
 * Covers the data, immediate, physical tag, opcode, flag and shift amount widths.
 */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// operand and result width.
`define EXEC_DATA_W 32

// immediate field carried with each instruction.
`define EXEC_IMM_W 16

// physical register tag width.
`define EXEC_TAG_W 6

// opcode width, enough for the 29 lane operations.
`define EXEC_OPCODE_W 5

// execution flags sent back with every result.
`define EXEC_FLAGS_W 6

// shift amount taken from the low bits of an operand or immediate.
`define EXEC_SHAMT_W 5

`endif

/* logic/exec_pkg.sv */
/*
 * Shared types for the simple integer execution lane.
 * Holds the ALU opcode enum and the packed execution flags.
 */
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

    // operations understood by the lane, in issue encoding order.
    typedef enum logic [`EXEC_OPCODE_W-1:0] {
        OP_ADD   = 5'd0,
        OP_ADDI  = 5'd1,
        OP_ADDU  = 5'd2,
        OP_ADDIU = 5'd3,
        OP_SUB   = 5'd4,
        OP_SUBU  = 5'd5,
        OP_MFHI  = 5'd6,
        OP_MTHI  = 5'd7,
        OP_MFLO  = 5'd8,
        OP_MTLO  = 5'd9,
        OP_AND   = 5'd10,
        OP_ANDI  = 5'd11,
        OP_OR    = 5'd12,
        OP_ORI   = 5'd13,
        OP_XOR   = 5'd14,
        OP_XORI  = 5'd15,
        OP_NOR   = 5'd16,
        OP_SLL   = 5'd17,
        OP_SLLV  = 5'd18,
        OP_SRL   = 5'd19,
        OP_SRLV  = 5'd20,
        OP_SRA   = 5'd21,
        OP_SRAV  = 5'd22,
        OP_SLT   = 5'd23,
        OP_SLTI  = 5'd24,
        OP_SLTU  = 5'd25,
        OP_SLTIU = 5'd26,
        OP_LUI   = 5'd27,
        OP_NOP   = 5'd28
    } alu_op_e;

    // flags travel with the result to the retire logic.
    // This lane never predicts, so pred_taken, cond_branch and mispredict stay low.
    typedef struct packed {
        logic pred_taken;
        logic dest_valid;
        logic cond_branch;
        logic executed;
        logic exception;
        logic mispredict;
    } exec_flags_t;

endpackage

`default_nettype wire

/* logic/issue_operand_stage.sv */
/*
 * Operand stage of the execution lane.
 * Registers the issued instruction and both source tags, then picks each
 * operand from the writeback bus when the tags match.
 */
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module issue_operand_stage (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire                       issue_valid_i,
    input  wire exec_pkg::alu_op_e    issue_op_i,
    input  wire [`EXEC_TAG_W-1:0]     src1_tag_i,
    input  wire [`EXEC_DATA_W-1:0]    src1_data_i,
    input  wire [`EXEC_TAG_W-1:0]     src2_tag_i,
    input  wire [`EXEC_DATA_W-1:0]    src2_data_i,
    input  wire [`EXEC_IMM_W-1:0]     imm_i,
    input  wire [`EXEC_TAG_W-1:0]     dest_tag_i,
    input  wire                       fwd_valid_i,
    input  wire                       fwd_dest_valid_i,
    input  wire [`EXEC_TAG_W-1:0]     fwd_tag_i,
    input  wire [`EXEC_DATA_W-1:0]    fwd_data_i,
    output logic                      op_valid_o,
    output exec_pkg::alu_op_e         op_code_o,
    output logic [`EXEC_DATA_W-1:0]   op_data1_o,
    output logic [`EXEC_DATA_W-1:0]   op_data2_o,
    output logic [`EXEC_IMM_W-1:0]    op_imm_o,
    output logic [`EXEC_TAG_W-1:0]    op_dest_tag_o
);
    import exec_pkg::*;

    logic                     valid_q;
    alu_op_e                  op_q;
    logic [`EXEC_TAG_W-1:0]   src1_tag_q;
    logic [`EXEC_DATA_W-1:0]  src1_data_q;
    logic [`EXEC_TAG_W-1:0]   src2_tag_q;
    logic [`EXEC_DATA_W-1:0]  src2_data_q;
    logic [`EXEC_IMM_W-1:0]   imm_q;
    logic [`EXEC_TAG_W-1:0]   dest_tag_q;
    logic                     fwd_live;
    logic                     fwd_hit1;
    logic                     fwd_hit2;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid_i;
        end
    end

    // the payload only loads when an instruction is actually issued.
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            op_q        <= issue_op_i;
            src1_tag_q  <= src1_tag_i;
            src1_data_q <= src1_data_i;
            src2_tag_q  <= src2_tag_i;
            src2_data_q <= src2_data_i;
            imm_q       <= imm_i;
            dest_tag_q  <= dest_tag_i;
        end
    end

    // A result only forwards if it really writes a register. A NOP on the bus is ignored.
    assign fwd_live = fwd_valid_i & fwd_dest_valid_i;
    assign fwd_hit1 = fwd_live && (src1_tag_q == fwd_tag_i);
    assign fwd_hit2 = fwd_live && (src2_tag_q == fwd_tag_i);

    assign op_valid_o    = valid_q;
    assign op_code_o     = op_q;
    assign op_data1_o    = fwd_hit1 ? fwd_data_i : src1_data_q;
    assign op_data2_o    = fwd_hit2 ? fwd_data_i : src2_data_q;
    assign op_imm_o      = imm_q;
    assign op_dest_tag_o = dest_tag_q;

endmodule

`default_nettype wire

/* logic/simple_alu.sv */
/*
 * Combinational integer ALU of the execution lane.
 * Computes the 32-bit result and the six execution flags for every opcode.
 */
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module simple_alu (
    input  wire [`EXEC_DATA_W-1:0]  data1_i,
    input  wire [`EXEC_DATA_W-1:0]  data2_i,
    input  wire [`EXEC_IMM_W-1:0]   immd_i,
    input  wire exec_pkg::alu_op_e  opcode_i,
    output logic [`EXEC_DATA_W-1:0] result_o,
    output exec_pkg::exec_flags_t   flags_o
);
    import exec_pkg::*;

    localparam int EXT_W = `EXEC_DATA_W - `EXEC_IMM_W;

    logic [`EXEC_DATA_W-1:0]  sext_imm;
    logic [`EXEC_DATA_W-1:0]  zext_imm;
    logic [`EXEC_SHAMT_W-1:0] reg_shamt;
    logic [`EXEC_SHAMT_W-1:0] imm_shamt;
    logic [`EXEC_DATA_W:0]    add_reg;
    logic [`EXEC_DATA_W:0]    add_imm;
    logic [`EXEC_DATA_W:0]    sub_reg;
    logic [`EXEC_DATA_W-1:0]  result;
    logic                     carry;
    logic [`EXEC_FLAGS_W-1:0] flags_vec;

    assign sext_imm = {{EXT_W{immd_i[`EXEC_IMM_W-1]}}, immd_i};
    assign zext_imm = {{EXT_W{1'b0}}, immd_i};

    // variable shifts use the low bits of operand 1, immediate shifts the immediate.
    assign reg_shamt = data1_i[`EXEC_SHAMT_W-1:0];
    assign imm_shamt = immd_i[`EXEC_SHAMT_W-1:0];

    // 33-bit sums so the top bit holds the carry or borrow.
    assign add_reg = {1'b0, data1_i} + {1'b0, data2_i};
    assign add_imm = {1'b0, data1_i} + {1'b0, sext_imm};
    assign sub_reg = {1'b0, data1_i} - {1'b0, data2_i};

    always_comb begin
        result = '0;
        carry  = 1'b0;
        case (opcode_i)
            OP_ADD: begin
                result = add_reg[`EXEC_DATA_W-1:0];
                carry  = add_reg[`EXEC_DATA_W];
            end
            OP_ADDI: begin
                result = add_imm[`EXEC_DATA_W-1:0];
                carry  = add_imm[`EXEC_DATA_W];
            end
            OP_ADDU: begin
                result = add_reg[`EXEC_DATA_W-1:0];
            end
            OP_ADDIU: begin
                result = add_imm[`EXEC_DATA_W-1:0];
            end
            OP_SUB: begin
                result = sub_reg[`EXEC_DATA_W-1:0];
                carry  = sub_reg[`EXEC_DATA_W];
            end
            OP_SUBU: begin
                result = sub_reg[`EXEC_DATA_W-1:0];
            end
            // HI/LO live outside the lane, so the moves just pass operand 1.
            OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO: begin
                result = data1_i;
            end
            OP_AND: begin
                result = data1_i & data2_i;
            end
            OP_ANDI: begin
                result = data1_i & zext_imm;
            end
            OP_OR: begin
                result = data1_i | data2_i;
            end
            OP_ORI: begin
                result = data1_i | zext_imm;
            end
            OP_XOR: begin
                result = data1_i ^ data2_i;
            end
            OP_XORI: begin
                result = data1_i ^ zext_imm;
            end
            OP_NOR: begin
                result = ~(data1_i | data2_i);
            end
            OP_SLL: begin
                result = data1_i << imm_shamt;
            end
            OP_SLLV: begin
                result = data2_i << reg_shamt;
            end
            OP_SRL: begin
                result = data1_i >> imm_shamt;
            end
            OP_SRLV: begin
                result = data2_i >> reg_shamt;
            end
            OP_SRA: begin
                result = $signed(data1_i) >>> imm_shamt;
            end
            OP_SRAV: begin
                result = $signed(data2_i) >>> reg_shamt;
            end
            OP_SLT: begin
                result = {{(`EXEC_DATA_W-1){1'b0}}, ($signed(data1_i) < $signed(data2_i))};
            end
            OP_SLTI: begin
                result = {{(`EXEC_DATA_W-1){1'b0}}, ($signed(data1_i) < $signed(sext_imm))};
            end
            OP_SLTU: begin
                result = {{(`EXEC_DATA_W-1){1'b0}}, (data1_i < data2_i)};
            end
            OP_SLTIU: begin
                result = {{(`EXEC_DATA_W-1){1'b0}}, (data1_i < zext_imm)};
            end
            OP_LUI: begin
                result = {immd_i, {EXT_W{1'b0}}};
            end
            // NOP and the unused encodings leave the result at zero.
            default: begin
                result = '0;
            end
        endcase
    end

    // order is pred_taken, dest_valid, cond_branch, executed, exception, mispredict.
    assign flags_vec = {1'b0,
                        (opcode_i != OP_NOP),
                        1'b0,
                        1'b1,
                        carry,
                        1'b0};

    assign result_o = result;
    assign flags_o  = flags_vec;

endmodule

`default_nettype wire

/* logic/alu_result_stage.sv */
/*
 * Result stage of the execution lane.
 * Registers the ALU result, flags and destination tag onto the writeback bus.
 */
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module alu_result_stage (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        valid_i,
    input  wire [`EXEC_TAG_W-1:0]      dest_tag_i,
    input  wire [`EXEC_DATA_W-1:0]     result_i,
    input  wire exec_pkg::exec_flags_t flags_i,
    output logic                       wb_valid_o,
    output logic [`EXEC_TAG_W-1:0]     wb_tag_o,
    output logic [`EXEC_DATA_W-1:0]    wb_data_o,
    output exec_pkg::exec_flags_t      wb_flags_o
);
    import exec_pkg::*;

    logic                    valid_q;
    logic [`EXEC_TAG_W-1:0]  tag_q;
    logic [`EXEC_DATA_W-1:0] data_q;
    exec_flags_t             flags_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // The lane never stalls, so the payload follows the ALU every cycle.
    always_ff @(posedge clk_i) begin
        tag_q   <= dest_tag_i;
        data_q  <= result_i;
        flags_q <= flags_i;
    end

    assign wb_valid_o = valid_q;
    assign wb_tag_o   = tag_q;
    assign wb_data_o  = data_q;
    assign wb_flags_o = flags_q;

endmodule

`default_nettype wire

/* logic/simple_exec_pipe.sv */
/*
 * Top level of the simple integer execution lane.
 * Chains the operand stage, the ALU and the result stage; writeback feeds forwarding.
 */
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module simple_exec_pipe (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        issue_valid_i,
    input  wire exec_pkg::alu_op_e     issue_op_i,
    input  wire [`EXEC_TAG_W-1:0]      src1_tag_i,
    input  wire [`EXEC_DATA_W-1:0]     src1_data_i,
    input  wire [`EXEC_TAG_W-1:0]      src2_tag_i,
    input  wire [`EXEC_DATA_W-1:0]     src2_data_i,
    input  wire [`EXEC_IMM_W-1:0]      imm_i,
    input  wire [`EXEC_TAG_W-1:0]      dest_tag_i,
    output logic                       wb_valid_o,
    output logic [`EXEC_TAG_W-1:0]     wb_tag_o,
    output logic [`EXEC_DATA_W-1:0]    wb_data_o,
    output exec_pkg::exec_flags_t      wb_flags_o
);
    import exec_pkg::*;

    logic                    op_valid;
    alu_op_e                 op_code;
    logic [`EXEC_DATA_W-1:0] op_data1;
    logic [`EXEC_DATA_W-1:0] op_data2;
    logic [`EXEC_IMM_W-1:0]  op_imm;
    logic [`EXEC_TAG_W-1:0]  op_dest_tag;
    logic [`EXEC_DATA_W-1:0] alu_result;
    exec_flags_t             alu_flags;

    // the writeback bus loops straight back as the forwarding source.
    issue_operand_stage u_operand_stage (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .issue_valid_i    (issue_valid_i),
        .issue_op_i       (issue_op_i),
        .src1_tag_i       (src1_tag_i),
        .src1_data_i      (src1_data_i),
        .src2_tag_i       (src2_tag_i),
        .src2_data_i      (src2_data_i),
        .imm_i            (imm_i),
        .dest_tag_i       (dest_tag_i),
        .fwd_valid_i      (wb_valid_o),
        .fwd_dest_valid_i (wb_flags_o.dest_valid),
        .fwd_tag_i        (wb_tag_o),
        .fwd_data_i       (wb_data_o),
        .op_valid_o       (op_valid),
        .op_code_o        (op_code),
        .op_data1_o       (op_data1),
        .op_data2_o       (op_data2),
        .op_imm_o         (op_imm),
        .op_dest_tag_o    (op_dest_tag)
    );

    simple_alu u_alu (
        .data1_i  (op_data1),
        .data2_i  (op_data2),
        .immd_i   (op_imm),
        .opcode_i (op_code),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    alu_result_stage u_result_stage (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (op_valid),
        .dest_tag_i (op_dest_tag),
        .result_i   (alu_result),
        .flags_i    (alu_flags),
        .wb_valid_o (wb_valid_o),
        .wb_tag_o   (wb_tag_o),
        .wb_data_o  (wb_data_o),
        .wb_flags_o (wb_flags_o)
    );

endmodule

`default_nettype wire

/* dv/exec_tb.sv */
/*
 * Directed testbench for the simple integer execution lane.
 * Holds clock, reset, watchdog, a reference model with forwarding,
 * an expected-result queue checked by a writeback monitor, and the tests.
 */
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module exec_tb;
    import exec_pkg::*;

    localparam int DW = `EXEC_DATA_W;
    localparam int IW = `EXEC_IMM_W;
    localparam int TW = `EXEC_TAG_W;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    // 1 + 10 + 13 + 15 + 6 + 200 instructions over all tests.
    localparam int PLANNED_ISSUES = 245;
    localparam int WATCHDOG_CYCLES = 20 * PLANNED_ISSUES + 100 + RESET_CYCLES;

    logic clk, rst_n, issue_valid, wb_valid;
    alu_op_e issue_op;
    logic [TW-1:0] src1_tag, src2_tag, dest_tag, wb_tag;
    logic [DW-1:0] src1_data, src2_data, wb_data;
    logic [IW-1:0] imm;
    exec_flags_t wb_flags;

    logic [TW-1:0] exp_tag_q[$];
    logic [DW-1:0] exp_data_q[$];
    exec_flags_t exp_flags_q[$];
    string test_name;
    integer seed;
    logic [TW-1:0] next_tag;

    // the instruction issued on the previous edge is on writeback while the next one forwards.
    logic last_valid, last_dest_valid;
    logic [TW-1:0] last_tag;
    logic [DW-1:0] last_result;

    simple_exec_pipe DUT (
        .clk_i(clk), .rst_n_i(rst_n), .issue_valid_i(issue_valid), .issue_op_i(issue_op),
        .src1_tag_i(src1_tag), .src1_data_i(src1_data), .src2_tag_i(src2_tag),
        .src2_data_i(src2_data), .imm_i(imm), .dest_tag_i(dest_tag),
        .wb_valid_o(wb_valid), .wb_tag_o(wb_tag), .wb_data_o(wb_data), .wb_flags_o(wb_flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_data(input string what, input logic [DW-1:0] exp_v, act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED test=%s %s expected=%h actual=%h",
                     test_name, what, exp_v, act_v);
            abort_run("writeback value mismatch");
        end
    endtask

    task automatic check_flags(input string what, input exec_flags_t exp_f, act_f);
        if (exp_f !== act_f) begin
            $display("CHECK FAILED test=%s %s expected=%b actual=%b",
                     test_name, what, exp_f, act_f);
            abort_run("writeback flags mismatch");
        end
    endtask

    // computes the expected result and flags from the lane's instruction rules.
    task automatic compute_expected(input alu_op_e op, input logic [DW-1:0] a, b,
                                    input logic [IW-1:0] im, output logic [DW-1:0] res,
                                    output exec_flags_t flg);
        logic [DW-1:0] se;
        logic [DW-1:0] ze;
        logic [DW:0] sum_r;
        logic [DW:0] sum_i;
        se = {{(DW - IW){im[IW-1]}}, im};
        ze = {{(DW - IW){1'b0}}, im};
        sum_r = {1'b0, a} + {1'b0, b};
        sum_i = {1'b0, a} + {1'b0, se};
        case (op)
            OP_ADD, OP_ADDU: res = sum_r[DW-1:0];
            OP_ADDI, OP_ADDIU: res = sum_i[DW-1:0];
            OP_SUB, OP_SUBU: res = a - b;
            OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO: res = a;
            OP_AND: res = a & b;
            OP_ANDI: res = a & ze;
            OP_OR: res = a | b;
            OP_ORI: res = a | ze;
            OP_XOR: res = a ^ b;
            OP_XORI: res = a ^ ze;
            OP_NOR: res = ~(a | b);
            OP_SLL: res = a << im[`EXEC_SHAMT_W-1:0];
            OP_SLLV: res = b << a[`EXEC_SHAMT_W-1:0];
            OP_SRL: res = a >> im[`EXEC_SHAMT_W-1:0];
            OP_SRLV: res = b >> a[`EXEC_SHAMT_W-1:0];
            OP_SRA: res = $signed(a) >>> im[`EXEC_SHAMT_W-1:0];
            OP_SRAV: res = $signed(b) >>> a[`EXEC_SHAMT_W-1:0];
            OP_SLT: res = ($signed(a) < $signed(b));
            OP_SLTI: res = ($signed(a) < $signed(se));
            OP_SLTU: res = (a < b);
            OP_SLTIU: res = (a < ze);
            OP_LUI: res = {im, {(DW - IW){1'b0}}};
            default: res = '0;
        endcase
        flg = '0;
        flg.executed = 1'b1;
        flg.dest_valid = (op != OP_NOP);
        // a borrow out of the 33-bit subtract happens exactly when a < b unsigned.
        flg.exception = (op == OP_ADD && sum_r[DW]) || (op == OP_ADDI && sum_i[DW])
                        || (op == OP_SUB && a < b);
    endtask

    task automatic issue_instr(input alu_op_e op, input logic [TW-1:0] t1, input logic [DW-1:0] d1,
                               input logic [TW-1:0] t2, input logic [DW-1:0] d2,
                               input logic [IW-1:0] im, input logic [TW-1:0] dest);
        logic [DW-1:0] eff1;
        logic [DW-1:0] eff2;
        logic [DW-1:0] res;
        exec_flags_t flg;
        @(negedge clk);
        eff1 = (last_valid && last_dest_valid && t1 == last_tag) ? last_result : d1;
        eff2 = (last_valid && last_dest_valid && t2 == last_tag) ? last_result : d2;
        compute_expected(op, eff1, eff2, im, res, flg);
        issue_valid = 1'b1;
        issue_op = op;
        src1_tag = t1;
        src1_data = d1;
        src2_tag = t2;
        src2_data = d2;
        imm = im;
        dest_tag = dest;
        exp_tag_q.push_back(dest);
        exp_data_q.push_back(res);
        exp_flags_q.push_back(flg);
        last_valid = 1'b1;
        last_dest_valid = flg.dest_valid;
        last_tag = dest;
        last_result = res;
    endtask

    // sources use tags 1 and 2, destinations cycle through 8..63, so nothing forwards.
    task automatic issue_no_dep(input alu_op_e op, input logic [DW-1:0] a, b,
                                input logic [IW-1:0] im);
        issue_instr(op, 1, a, 2, b, im, next_tag);
        next_tag = (next_tag == 6'd63) ? 6'd8 : next_tag + 1'b1;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        issue_valid = 1'b0;
        last_valid = 1'b0;
    endtask

    task automatic wait_drained();
        idle_cycle();
        while (exp_data_q.size() != 0) idle_cycle();
    endtask

    always @(negedge clk) begin : writeback_monitor
        logic [TW-1:0] e_tag;
        logic [DW-1:0] e_data;
        exec_flags_t e_flags;
        if (rst_n === 1'b1 && wb_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                abort_run("a writeback arrived while no instruction was outstanding");
            end else begin
                e_tag = exp_tag_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_flags = exp_flags_q.pop_front();
                check_data("tag", e_tag, wb_tag);
                check_data("data", e_data, wb_data);
                check_flags("flags", e_flags, wb_flags);
            end
        end
    end

    task automatic reset_and_latency();
        test_name = "reset_and_latency";
        repeat (5) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) abort_run("wb_valid_o went high after reset with no issue");
        end
        issue_instr(OP_ADD, 1, 32'd1234, 2, 32'd4321, 16'h0, 6'd33);
        idle_cycle();
        if (wb_valid !== 1'b0) abort_run("the ADD came back one cycle early");
        idle_cycle();
        if (wb_valid !== 1'b1) abort_run("the ADD was not on writeback two cycles after issue");
        wait_drained();
    endtask

    task automatic arith_and_flags();
        test_name = "arith_and_flags";
        issue_no_dep(OP_ADD, 32'hFFFF_FFFF, 32'h1, 16'h0);
        issue_no_dep(OP_ADD, 32'd5, 32'd7, 16'h0);
        issue_no_dep(OP_ADDI, 32'h7FFF_FFF0, 32'h0, 16'h0020);
        issue_no_dep(OP_ADDI, 32'd10, 32'h0, 16'hFFFF);
        issue_no_dep(OP_ADDU, 32'hFFFF_FFFF, 32'h2, 16'h0);
        issue_no_dep(OP_ADDIU, 32'd3, 32'h0, 16'h8000);
        issue_no_dep(OP_ADDIU, 32'hFFFF_FFFF, 32'h0, 16'h0001);
        issue_no_dep(OP_SUB, 32'd3, 32'd5, 16'h0);
        issue_no_dep(OP_SUB, 32'd9, 32'd4, 16'h0);
        issue_no_dep(OP_SUBU, 32'd3, 32'd5, 16'h0);
        wait_drained();
    endtask

    task automatic logic_moves_lui();
        alu_op_e ops [12] = '{OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR,
                              OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO, OP_LUI};
        test_name = "logic_moves_lui";
        for (int i = 0; i < 12; i++) begin
            issue_no_dep(ops[i], $random(seed), $random(seed), $random(seed));
        end
        issue_no_dep(OP_NOP, $random(seed), $random(seed), $random(seed));
        wait_drained();
    endtask

    task automatic shifts_and_compares();
        test_name = "shifts_and_compares";
        issue_no_dep(OP_SLL, 32'h8000_0F01, 32'h0, 16'hFFE4);
        issue_no_dep(OP_SRL, 32'h8000_0F01, 32'h0, 16'h001F);
        issue_no_dep(OP_SRA, 32'h8000_0F01, 32'h0, 16'h0007);
        issue_no_dep(OP_SLLV, 32'd35, 32'h1234_5678, 16'h0);
        issue_no_dep(OP_SRLV, 32'hFFFF_FFE1, 32'h8765_4321, 16'h0);
        issue_no_dep(OP_SRAV, 32'd63, 32'h8000_0000, 16'h0);
        issue_no_dep(OP_SRAV, 32'd36, 32'hF000_00F0, 16'h0);
        issue_no_dep(OP_SLT, 32'hFFFF_FFFB, 32'd3, 16'h0);
        issue_no_dep(OP_SLT, 32'd3, 32'hFFFF_FFFB, 16'h0);
        issue_no_dep(OP_SLTU, 32'hFFFF_FFFB, 32'd3, 16'h0);
        issue_no_dep(OP_SLTU, 32'd3, 32'hFFFF_FFFB, 16'h0);
        issue_no_dep(OP_SLTI, 32'hFFFF_FFFB, 32'h0, 16'hFFFE);
        issue_no_dep(OP_SLTI, 32'h0, 32'h0, 16'h8000);
        issue_no_dep(OP_SLTIU, 32'h0000_7000, 32'h0, 16'h8000);
        issue_no_dep(OP_SLTIU, 32'hFFFF_FFFF, 32'h0, 16'hFFFF);
        wait_drained();
    endtask

    // each consumer carries a stale value for the tag it names, so only forwarding fixes it.
    task automatic forwarding_chain();
        test_name = "forwarding_chain";
        issue_instr(OP_ADDI, 4, 32'd100, 5, 32'h0, 16'd5, 20);
        issue_instr(OP_ADD, 20, 32'hDEAD_BEEF, 6, 32'd7, 16'h0, 21);
        issue_instr(OP_SUB, 7, 32'd1000, 21, 32'hBAD0_BAD0, 16'h0, 22);
        issue_instr(OP_SLLV, 22, 32'h1111_1111, 22, 32'h2222_2222, 16'h0, 23);
        issue_instr(OP_NOP, 23, 32'h3333_3333, 9, 32'h0, 16'h0, 24);
        issue_instr(OP_OR, 24, 32'h0000_00F0, 9, 32'h0000_000F, 16'h0, 25);
        wait_drained();
    endtask

    task automatic random_stream();
        logic [TW-1:0] t1;
        logic [TW-1:0] t2;
        int unsigned op_idx;
        test_name = "random_stream";
        for (int n = 0; n < 200; n++) begin
            op_idx = {$random(seed)} % 29;
            t1 = $random(seed);
            t2 = $random(seed);
            if (last_valid && t1 == last_tag) t1 = t1 + 1'b1;
            if (last_valid && t2 == last_tag) t2 = t2 + 1'b1;
            issue_instr(alu_op_e'(op_idx), t1, $random(seed), t2, $random(seed),
                        $random(seed), $random(seed));
            repeat ({$random(seed)} % 3) idle_cycle();
        end
        wait_drained();
    endtask

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        abort_run("watchdog expired before all results were written back");
    end

    initial begin
        seed = 31946;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_op = OP_NOP;
        src1_tag = '0;
        src1_data = '0;
        src2_tag = '0;
        src2_data = '0;
        imm = '0;
        dest_tag = '0;
        last_valid = 1'b0;
        last_dest_valid = 1'b0;
        last_tag = '0;
        last_result = '0;
        next_tag = 6'd8;
        test_name = "reset";
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        reset_and_latency();
        arith_and_flags();
        logic_moves_lui();
        shifts_and_compares();
        forwarding_chain();
        random_stream();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/exec_pkg.sv
logic/issue_operand_stage.sv
logic/simple_alu.sv
logic/alu_result_stage.sv
logic/simple_exec_pipe.sv
dv/exec_tb.sv

/* Bender.yml */
package:
  name: simple_exec_pipe

sources:
  - include_dirs:
      - logic
    files:
      - logic/exec_pkg.sv
      - logic/issue_operand_stage.sv
      - logic/simple_alu.sv
      - logic/alu_result_stage.sv
      - logic/simple_exec_pipe.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/exec_tb.sv
